// ==== include/rsc2_trellis.svh ====
`ifndef RSC2_TRELLIS_SVH
`define RSC2_TRELLIS_SVH

// ----------------------------------------
// duobinary rsc trellis, 16 states
// ----------------------------------------
// state s = {s3 s2 s1 s0}, symbol u = {u1 u0}
// shift by two bits per symbol, feedback from the top pair

// next state reached from s with input symbol u
function automatic logic [3:0] next_state (input logic [3:0] s, input logic [1:0] u);
  return {s[1:0], u ^ s[3:2]};  // low pair moves up
endfunction

// unique predecessor of n for input symbol u
// low pair of n is u ^ s[3:2], top pair of n is s[1:0]
function automatic logic [3:0] pre_state (input logic [3:0] n, input logic [1:0] u);
  return {n[1:0] ^ u, n[3:2]};
endfunction

// parity bit emitted on the branch (s, u)
function automatic logic parity (input logic [3:0] s, input logic [1:0] u);
  return (^s) ^ (^u);           // xor over state and symbol bits
endfunction

`endif

// ==== source/rsc2_dec_pkg.sv ====
package rsc2_dec_pkg;

  // ----------------------------------------
  // widths and sizes
  // ----------------------------------------

  localparam int cLLR_W    = 5;   // signed symbol llr
  localparam int cSTATE_W  = 8;   // modulo metric, wraps freely
  localparam int cSTATES   = 16;  // trellis states
  localparam int cBRANCHES = 4;   // two bits per symbol

  // ----------------------------------------
  // metric types
  // ----------------------------------------

  typedef logic signed [cLLR_W-1:0] llr_t;

  // one state metric, unsigned modulo 2**cSTATE_W
  typedef logic [cSTATE_W-1:0] trel_state_t;

  // alpha vector, index is the state
  typedef trel_state_t [cSTATES-1:0] state_t;

  // metrics of the four branches leaving one state
  typedef trel_state_t [cBRANCHES-1:0] branch_t;

  // gamma(s, u), first index state, second index symbol
  typedef branch_t [cSTATES-1:0] gamma_t;

  // metric relative to state 0, read as signed
  typedef logic signed [cSTATE_W-1:0] rel_t;
  typedef rel_t [cSTATES-1:0] rel_vec_t;

  // four-phase req/ack sequencing
  typedef enum logic [1:0] {
    hs_idle,  // nothing held
    hs_busy,  // data held, req/ack phase open
    hs_done   // ack seen, waiting for it to fall
  } hs_state_t;

  // ----------------------------------------
  // trellis
  // ----------------------------------------

  `include "rsc2_trellis.svh"

endpackage

// ==== source/rsc2_dec_gamma_if.sv ====
`timescale 1ns/100ps

interface rsc2_dec_gamma_if
  import rsc2_dec_pkg::*;
();

  logic   val;    // gamma valid for one recursion step
  logic   clr;    // frame start, alpha back to zero
  gamma_t gamma;  // branch metrics of the current symbol
  logic   stall;  // output side full, hold everything

  // input side makes the metrics
  modport bmc (output val, clr, gamma, input stall);

  // recursion consumes them, stall is its inverted clock enable
  modport rp  (input val, clr, gamma, stall);

  // output side raises the back-pressure
  modport out (output stall);

endinterface

// ==== source/rsc2_dec_bmc.sv ====
`timescale 1ns/100ps

module rsc2_dec_bmc
  import rsc2_dec_pkg::*;
(
  input  logic iclk,
  input  logic ireset,
  // symbol in, four-phase req/ack
  input  logic in_req,
  input  logic in_sof,  // first symbol of a frame
  input  llr_t in_l01,
  input  llr_t in_l10,
  input  llr_t in_l11,
  input  llr_t in_lp,   // parity llr
  output logic in_ack,
  //
  rsc2_dec_gamma_if.bmc gif
);

  hs_state_t             hs_state;
  logic                  capture;
  llr_t                  l01_r, l10_r, l11_r, lp_r;  // symbol register
  llr_t [cBRANCHES-1:0]  l_sym;                      // L[u], L[0] is zero

  // llr to modulo metric width
  function automatic trel_state_t sext (input llr_t l);
    return {{(cSTATE_W-cLLR_W){l[cLLR_W-1]}}, l};
  endfunction

  // ----------------------------------------
  // input handshake
  // ----------------------------------------

  // a pending clear still needs this symbol's val, so hold off
  assign capture = (hs_state == hs_idle) & in_req & ~gif.stall & ~gif.clr;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      hs_state <= hs_idle;
      in_ack   <= 1'b0;
      gif.val  <= 1'b0;
      gif.clr  <= 1'b0;
    end
    else begin
      if (!gif.stall) begin     // rp takes val/clr on this edge
        gif.clr <= 1'b0;
        gif.val <= gif.clr;     // clear cycle, then the symbol itself
      end
      case (hs_state)
        hs_idle : if (capture) begin
          in_ack   <= 1'b1;
          gif.clr  <= in_sof;   // sof restarts alpha first
          gif.val  <= ~in_sof;
          hs_state <= hs_busy;
        end
        hs_busy : if (!in_req) begin  // source let go
          in_ack   <= 1'b0;
          hs_state <= hs_idle;
        end
        default : hs_state <= hs_idle;
      endcase
    end
  end

  always_ff @(posedge iclk) begin
    if (capture) begin
      l01_r <= in_l01;
      l10_r <= in_l10;
      l11_r <= in_l11;
      lp_r  <= in_lp;
    end
  end

  // ----------------------------------------
  // branch metrics
  // ----------------------------------------

  assign l_sym = {l11_r, l10_r, l01_r, llr_t'(0)};

  always_comb begin
    for (int s = 0; s < cSTATES; s++) begin
      for (int u = 0; u < cBRANCHES; u++) begin
        gif.gamma[s][u] = sext(l_sym[u]);           // systematic part
        if (parity(4'(s), 2'(u))) begin
          gif.gamma[s][u] = gif.gamma[s][u] + sext(lp_r);  // parity 1 adds lp
        end
      end
    end
  end

endmodule

// ==== source/rsc2_dec_rp_mod.sv ====
`timescale 1ns/100ps

module rsc2_dec_rp_mod
  import rsc2_dec_pkg::*;
(
  input  logic   iclk,
  input  logic   ireset,
  //
  rsc2_dec_gamma_if.rp gif,
  //
  output logic   oval,
  output state_t ostate   // alpha[k+1]
);

  logic        clkena;
  gamma_t      gamma_acc;   // alpha(s) + gamma(s, u)
  state_t      alpha;
  state_t      alpha_next;  // before normalization
  state_t      alpha_norm;
  trel_state_t norm_value;

  // ----------------------------------------
  // recursion functions
  // ----------------------------------------

  function automatic gamma_t gamma_p_alpha (input gamma_t ga, input state_t al);
    gamma_t acc;
    for (int s = 0; s < cSTATES; s++) begin
      for (int u = 0; u < cBRANCHES; u++) begin
        acc[s][u] = ga[s][u] + al[s];  // wraps, fine in modulo domain
      end
    end
    return acc;
  endfunction

  // parallel modulo max, all pairs compared at once
  function automatic trel_state_t mod_max4 (input branch_t c);
    trel_state_t          diff;
    logic [cBRANCHES-1:0] win;   // candidate not behind any other
    trel_state_t          res;
    win = '1;
    for (int i = 0; i < cBRANCHES; i++) begin
      for (int j = 0; j < cBRANCHES; j++) begin
        diff = c[i] - c[j];
        if (diff[cSTATE_W-1]) begin  // c[i] < c[j] on the circle
          win[i] = 1'b0;
        end
      end
    end
    res = c[0];
    for (int i = cBRANCHES-1; i >= 0; i--) begin
      if (win[i]) begin
        res = c[i];                  // lowest winner kept
      end
    end
    return res;
  endfunction

  // alpha(n, k+1) = max over u of acc(pre_state(n, u), u)
  function automatic state_t get_next_alpha (input gamma_t acc);
    branch_t cand;
    state_t  na;
    for (int n = 0; n < cSTATES; n++) begin
      for (int u = 0; u < cBRANCHES; u++) begin
        cand[u] = acc[pre_state(4'(n), 2'(u))][u];
      end
      na[n] = mod_max4(cand);
    end
    return na;
  endfunction

  // quadrant rule on the top two bits of every metric
  function automatic trel_state_t get_norm_value (input state_t st);
    logic [3:0]  seen;  // one flag per quadrant
    trel_state_t nv;
    seen = '0;
    for (int s = 0; s < cSTATES; s++) begin
      seen[st[s][cSTATE_W-1 -: 2]] = 1'b1;
    end
    nv = '0;
    if (seen[3] && !seen[0]) begin
      nv = {2'b01, {(cSTATE_W-2){1'b0}}};  // 11 wraps to 00
    end
    else if (seen[2]) begin
      nv = {2'b10, {(cSTATE_W-2){1'b0}}};
    end
    else if (seen[1]) begin
      nv = {2'b11, {(cSTATE_W-2){1'b0}}};
    end
    return nv;
  endfunction

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  assign clkena     = ~gif.stall;  // output side full, freeze
  assign gamma_acc  = gamma_p_alpha(gif.gamma, alpha);
  assign alpha_next = get_next_alpha(gamma_acc);
  assign norm_value = get_norm_value(alpha_next);

  always_comb begin
    for (int s = 0; s < cSTATES; s++) begin
      alpha_norm[s] = alpha_next[s] + norm_value;  // same shift for all
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval  <= 1'b0;
      alpha <= '0;
    end
    else if (clkena) begin
      oval <= gif.val;           // one tick latency
      if (gif.clr) begin
        alpha <= '0;             // frame start
      end
      else if (gif.val) begin
        alpha <= alpha_norm;
      end
    end
  end

  assign ostate = alpha;

endmodule

// ==== source/rsc2_dec_out.sv ====
`timescale 1ns/100ps

module rsc2_dec_out
  import rsc2_dec_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  //
  input  logic       ival,      // new alpha from rp
  input  state_t     istate,
  //
  rsc2_dec_gamma_if.out gif,
  // result out, four-phase req/ack
  output logic       out_req,
  output logic [3:0] out_best,
  output rel_vec_t   out_rel,
  input  logic       out_ack
);

  hs_state_t hs_state;
  state_t    cap;       // held alpha vector

  // best state by modulo difference, lowest index on ties
  function automatic logic [3:0] find_best (input state_t st);
    logic [3:0]  best;
    trel_state_t diff;
    best = '0;
    for (int s = 1; s < cSTATES; s++) begin
      diff = st[s] - st[best];
      if (!diff[cSTATE_W-1] && (diff != '0)) begin  // strictly ahead
        best = s[3:0];
      end
    end
    return best;
  endfunction

  // ----------------------------------------
  // capture and output handshake
  // ----------------------------------------

  // result still out and another one waiting
  assign gif.stall = ival & (hs_state != hs_idle);

  always_ff @(posedge iclk) begin
    if ((hs_state == hs_idle) && ival) begin
      cap <= istate;
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      hs_state <= hs_idle;
      out_req  <= 1'b0;
    end
    else begin
      case (hs_state)
        hs_idle : if (ival) hs_state <= hs_busy;  // captured this edge
        hs_busy : begin
          if (!out_req) begin
            out_req <= 1'b1;                      // one tick after capture
          end
          else if (out_ack) begin
            out_req  <= 1'b0;
            hs_state <= hs_done;
          end
        end
        hs_done : if (!out_ack) hs_state <= hs_idle;  // sink released ack
        default : hs_state <= hs_idle;
      endcase
    end
  end

  // ----------------------------------------
  // result
  // ----------------------------------------

  assign out_best = find_best(cap);

  always_comb begin
    for (int s = 0; s < cSTATES; s++) begin
      out_rel[s] = rel_t'(cap[s] - cap[0]);  // wrap cancels out
    end
  end

endmodule

// ==== source/rsc2_dec_top.sv ====
`timescale 1ns/100ps

module rsc2_dec_top
  import rsc2_dec_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  // symbol in
  input  logic       in_req,
  input  logic       in_sof,
  input  llr_t       in_l01,
  input  llr_t       in_l10,
  input  llr_t       in_l11,
  input  llr_t       in_lp,
  output logic       in_ack,
  // result out
  output logic       out_req,
  output logic [3:0] out_best,
  output rel_vec_t   out_rel,
  input  logic       out_ack
);

  logic   rp_oval;   // alpha step done
  state_t rp_state;  // alpha[k+1]

  rsc2_dec_gamma_if gif ();  // bmc -> rp metrics, stall from out

  rsc2_dec_bmc rsc2_dec_bmc (
    .iclk    ( iclk    ),
    .ireset  ( ireset  ),
    .in_req  ( in_req  ),
    .in_sof  ( in_sof  ),
    .in_l01  ( in_l01  ),
    .in_l10  ( in_l10  ),
    .in_l11  ( in_l11  ),
    .in_lp   ( in_lp   ),
    .in_ack  ( in_ack  ),
    .gif     ( gif.bmc )
  );

  rsc2_dec_rp_mod rsc2_dec_rp_mod (
    .iclk    ( iclk     ),
    .ireset  ( ireset   ),
    .gif     ( gif.rp   ),
    .oval    ( rp_oval  ),
    .ostate  ( rp_state )
  );

  rsc2_dec_out rsc2_dec_out (
    .iclk     ( iclk     ),
    .ireset   ( ireset   ),
    .ival     ( rp_oval  ),
    .istate   ( rp_state ),
    .gif      ( gif.out  ),
    .out_req  ( out_req  ),
    .out_best ( out_best ),
    .out_rel  ( out_rel  ),
    .out_ack  ( out_ack  )
  );

endmodule

// ==== testbench/rsc2_dec_tb_assertions.sv ====
`timescale 1ns/100ps

module rsc2_dec_tb_assertions
  import rsc2_dec_pkg::*;
(
  input logic       iclk,
  input logic       ireset,
  input logic       in_req,
  input logic       in_ack,
  input logic       out_req,
  input logic       out_ack,
  input logic [3:0] out_best,
  input rel_vec_t   out_rel
);

  int fail_count = 0;  // failed assertions so far

  // source keeps req up until the ack arrives
  a_in_req_hold : assert property (@(posedge iclk) disable iff (ireset)
    in_req && !in_ack |=> in_req || in_ack)
    else begin
      fail_count++;
      $error("in_req dropped before in_ack");
    end

  // result stays offered until the sink acks
  a_out_req_hold : assert property (@(posedge iclk) disable iff (ireset)
    out_req && !out_ack |=> out_req)
    else begin
      fail_count++;
      $error("out_req dropped before out_ack");
    end

  // held result must not move under an open req
  a_out_stable : assert property (@(posedge iclk) disable iff (ireset)
    out_req && !out_ack |=> $stable(out_best) && $stable(out_rel))
    else begin
      fail_count++;
      $error("out_best or out_rel changed while out_req was pending");
    end

  a_reset_quiet : assert property (@(posedge iclk)
    ireset |-> !in_ack && !out_req)
    else begin
      fail_count++;
      $error("in_ack or out_req high during reset");
    end

endmodule

bind rsc2_dec_top rsc2_dec_tb_assertions handshake_checks (.*);

// ==== testbench/rsc2_dec_tb.sv ====
`timescale 1ns/100ps

module rsc2_dec_tb
  import rsc2_dec_pkg::*;
();

  // one table row, stimulus plus model results
  typedef struct {
    logic sof;
    llr_t l01;
    llr_t l10;
    llr_t l11;
    llr_t lp;
    int   delay;            // sink ack delay in cycles
    int   tid;              // test the row belongs to
    int   best;
    int   rel [cSTATES];
  } row_t;

  logic       iclk = 1'b0;
  logic       ireset;
  logic       in_req, in_sof, in_ack;
  llr_t       in_l01, in_l10, in_l11, in_lp;
  logic       out_req, out_ack;
  logic [3:0] out_best;
  rel_vec_t   out_rel;

  row_t  tbl [$];
  int    model_alpha [cSTATES];   // unbounded alpha, no wrap
  int    seed       = 32'hebeccc68;
  int    errors     = 0;
  int    inputs     = 0;          // in_ack rises seen
  int    outputs    = 0;          // out_req rises seen
  int    wait_limit = 400;        // cycles per handshake wait
  bit    aborted    = 1'b0;       // set on any timeout
  string test_name [4] = '{"directed", "long_pos", "long_mixed", "random_bp"};

  always #4 iclk = ~iclk;         // 8 ns period

  rsc2_dec_top DUT (.*);

  // symbols accepted and results offered, counted on the wires
  always @(posedge in_ack) begin
    inputs++;
  end

  always @(posedge out_req) begin
    outputs++;
  end

  // ----------------------------------------
  // reference model and table
  // ----------------------------------------

  function automatic logic branch_parity(input int s, input int u);
    return ^{s[3:0], u[1:0]};     // xor over state and symbol bits
  endfunction

  function automatic int rand_between(input int lo, input int hi);
    int r;
    r = $random(seed);
    return lo + int'($unsigned(r) % (hi - lo + 1));
  endfunction

  function automatic int extreme_llr();
    return (rand_between(0, 1) != 0) ? 15 : -16;
  endfunction

  task automatic add_row(input logic sof, input int l01, input int l10, input int l11,
                         input int lp, input int delay, input int tid);
    row_t r;
    int   lsym [cBRANCHES];
    int   na [cSTATES];
    int   n;
    int   cand;
    if (sof) begin
      foreach (model_alpha[s]) begin
        model_alpha[s] = 0;       // frame restart
      end
    end
    lsym = '{0, l01, l10, l11};   // L[0] is zero
    foreach (na[k]) begin
      na[k] = -(1 << 30);
    end
    // push every branch forward to its next state
    for (int s = 0; s < cSTATES; s++) begin
      for (int u = 0; u < cBRANCHES; u++) begin
        n    = {s[1:0], u[1:0] ^ s[3:2]};
        cand = model_alpha[s] + lsym[u] + (branch_parity(s, u) ? lp : 0);
        if (cand > na[n]) begin
          na[n] = cand;
        end
      end
    end
    model_alpha = na;
    r.best = 0;
    for (int s = 1; s < cSTATES; s++) begin
      if (model_alpha[s] > model_alpha[r.best]) begin
        r.best = s;               // strict, lowest index wins ties
      end
    end
    for (int s = 0; s < cSTATES; s++) begin
      r.rel[s] = model_alpha[s] - model_alpha[0];
    end
    r.sof   = sof;
    r.l01   = llr_t'(l01);
    r.l10   = llr_t'(l10);
    r.l11   = llr_t'(l11);
    r.lp    = llr_t'(lp);
    r.delay = delay;
    r.tid   = tid;
    tbl.push_back(r);
  endtask

  task automatic build_table();
    // directed: ties, extremes, sign flips, restart mid-stream
    add_row(1, 0, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 0, 1, 0);
    add_row(1, 15, 15, 15, 15, 2, 0);
    add_row(0, -16, -16, -16, -16, 0, 0);
    add_row(1, -16, 15, -16, 15, 4, 0);
    add_row(0, 15, -16, 15, -16, 0, 0);
    add_row(1, 0, 0, 0, 0, 3, 0);
    add_row(0, 7, -3, 1, -8, 0, 0);
    // steady growth of ~30 per symbol, many wraps
    for (int i = 0; i < 200; i++) begin
      add_row(i == 0, 15, 15, 15, extreme_llr(), 0, 1);
    end
    for (int i = 0; i < 200; i++) begin
      add_row(i == 0, extreme_llr(), extreme_llr(), extreme_llr(), rand_between(-8, 7),
              rand_between(0, 3), 2);
    end
    // random frames, occasional long sink stalls
    for (int i = 0; i < 60; i++) begin
      add_row(i == 0 || rand_between(0, 7) == 0, rand_between(-11, 11),
              rand_between(-11, 11), rand_between(-11, 11), rand_between(-11, 11),
              (rand_between(0, 3) == 0) ? rand_between(10, 40) : rand_between(0, 4), 3);
    end
  endtask

  // ----------------------------------------
  // checks and waits
  // ----------------------------------------

  task automatic check_value(input string name, input logic signed [31:0] got,
                             input logic signed [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_in_ack(input logic level, output bit ok);
    int n;
    n = 0;
    while (in_ack !== level && n < wait_limit && !aborted) begin
      @(negedge iclk);
      n++;
    end
    ok = (in_ack === level);
    if (!ok && !aborted) begin
      $display("timeout at %0t: in_ack never went to %0d", $time, level);
      errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic wait_out_req(input logic level, output bit ok);
    int n;
    n = 0;
    while (out_req !== level && n < wait_limit && !aborted) begin
      @(negedge iclk);
      n++;
    end
    ok = (out_req === level);
    if (!ok && !aborted) begin
      $display("timeout at %0t: out_req never went to %0d", $time, level);
      errors++;
      aborted = 1'b1;
    end
  endtask

  // ----------------------------------------
  // input and output sides
  // ----------------------------------------

  task automatic drive_inputs();
    bit ok;
    foreach (tbl[i]) begin
      if (aborted) begin
        break;
      end
      in_sof = tbl[i].sof;
      in_l01 = tbl[i].l01;
      in_l10 = tbl[i].l10;
      in_l11 = tbl[i].l11;
      in_lp  = tbl[i].lp;
      in_req = 1'b1;
      wait_in_ack(1'b1, ok);
      if (!ok) begin
        break;
      end
      in_req = 1'b0;
      wait_in_ack(1'b0, ok);      // ack falls one cycle later
      if (!ok) begin
        break;
      end
    end
    in_req = 1'b0;
  endtask

  task automatic collect_outputs();
    bit ok;
    int err_mark;
    int n_test;
    err_mark = 0;
    n_test   = 0;
    foreach (tbl[i]) begin
      if (aborted) begin
        break;
      end
      wait_out_req(1'b1, ok);
      if (!ok) begin
        break;
      end
      repeat (tbl[i].delay) @(negedge iclk);   // slow sink, back-pressure
      check_value("out_best", out_best, tbl[i].best);
      for (int s = 0; s < cSTATES; s++) begin
        check_value($sformatf("out_rel[%0d]", s), out_rel[s], tbl[i].rel[s]);
      end
      out_ack = 1'b1;
      wait_out_req(1'b0, ok);
      if (!ok) begin
        break;
      end
      out_ack = 1'b0;
      n_test++;
      if (i == tbl.size() - 1 || tbl[i+1].tid != tbl[i].tid) begin   // last row of a test
        $display("test %0s: %0d results, %0d errors", test_name[tbl[i].tid], n_test,
                 errors - err_mark);
        err_mark = errors;
        n_test   = 0;
      end
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    ireset  = 1'b1;
    in_req  = 1'b0;
    in_sof  = 1'b0;
    in_l01  = '0;
    in_l10  = '0;
    in_l11  = '0;
    in_lp   = '0;
    out_ack = 1'b0;
    build_table();
    repeat (4) @(negedge iclk);
    ireset = 1'b0;
    check_value("out_req", out_req, 0);
    check_value("in_ack", in_ack, 0);
    fork
      drive_inputs();
      collect_outputs();
    join
    if (!aborted) begin
      for (int k = 0; k < 40; k++) begin
        @(negedge iclk);
        if (out_req !== 1'b0) begin
          $display("an extra result appeared after the last symbol at %0t", $time);
          errors++;
          break;
        end
      end
      check_value("output count", outputs, inputs);
    end
    check_value("assertion failures", DUT.handshake_checks.fail_count, 0);
    $display("summary: 4 tests, %0d rows, %0d outputs, %0d errors", tbl.size(), outputs,
             errors);
    if (errors == 0) begin
      $display("TEST OK");
    end
    else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
source/rsc2_dec_pkg.sv
source/rsc2_dec_gamma_if.sv
source/rsc2_dec_bmc.sv
source/rsc2_dec_rp_mod.sv
source/rsc2_dec_out.sv
source/rsc2_dec_top.sv
testbench/rsc2_dec_tb_assertions.sv
testbench/rsc2_dec_tb.sv
